/* pp_reorder_consts.svh */
`ifndef PP_REORDER_CONSTS_SVH
`define PP_REORDER_CONSTS_SVH

// --------------------
// datapath sizes

// one sample
`define DATA_WIDTH 8

// bank address, one frame fills one bank
`define ADDR_WIDTH 4

// --------------------
// framing

// samples per frame
`define FRAME_LEN (1 << `ADDR_WIDTH)

`endif

/* pp_reorder_pkg.sv */
`include "pp_reorder_consts.svh"

package pp_reorder_pkg;

    // order in which a finished frame leaves the buffer
    typedef enum logic {
        ORDER_LINEAR   = 1'b0,
        ORDER_REVERSED = 1'b1
    } order_e;

    // --------------------
    // bank ports

    // one write port of a bank
    typedef struct packed {
        logic                   en;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
    } wr_port_t;

    // one read port of a bank
    typedef struct packed {
        logic                   en;
        logic [`ADDR_WIDTH-1:0] addr;
    } rd_port_t;

    // --------------------
    // FSM states

    // writer sweeps zeros first, then fills frames
    typedef enum logic {
        ST_CLEAR = 1'b0,
        ST_FILL  = 1'b1
    } wr_state_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_READ = 1'b1
    } rd_state_e;

endpackage

/* dp_ram.sv */
`include "pp_reorder_consts.svh"

module dp_ram import pp_reorder_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  wr_port_t               wr,
    input  rd_port_t               rd,
    output logic [`DATA_WIDTH-1:0] rdata
);

    // one word per address
    localparam int DEPTH = 1 << `ADDR_WIDTH;

    logic [`DATA_WIDTH-1:0] mem [DEPTH];

    // --------------------
    // write side

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // --------------------
    // read side

    // old word comes out when a write hits the same address
    // output holds while rd.en is low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (rd.en) begin
            rdata <= mem[rd.addr];
        end
    end

endmodule

/* pq_buffer.sv */
`include "pp_reorder_consts.svh"

module pq_buffer import pp_reorder_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ctrl,
    input  logic                   clear,
    input  wr_port_t               wr1,
    input  wr_port_t               wr2,
    input  rd_port_t               rd1,
    input  rd_port_t               rd2,
    output logic [`DATA_WIDTH-1:0] dout1,
    output logic [`DATA_WIDTH-1:0] dout2
);

    localparam int FRAME_LEN = `FRAME_LEN;

    wr_port_t               bank1_wr;
    wr_port_t               bank2_wr;
    rd_port_t               bank1_rd;
    rd_port_t               bank2_rd;
    logic [`DATA_WIDTH-1:0] bank1_q;
    logic [`DATA_WIDTH-1:0] bank2_q;
    logic                   ctrl_q;

    // --------------------
    // port crossing

    // ctrl high puts port 1 on bank 1 and port 2 on bank 2
    // clear writes both banks at the port-1 address
    always_comb begin
        bank1_wr.en   = clear | (ctrl ? wr1.en : wr2.en);
        bank1_wr.addr = (clear | ctrl) ? wr1.addr : wr2.addr;
        bank1_wr.data = (clear | ctrl) ? wr1.data : wr2.data;

        bank2_wr.en   = clear | (ctrl ? wr2.en : wr1.en);
        bank2_wr.addr = (clear | !ctrl) ? wr1.addr : wr2.addr;
        bank2_wr.data = (clear | ctrl) ? wr2.data : wr1.data;

        bank1_rd = ctrl ? rd1 : rd2;
        bank2_rd = ctrl ? rd2 : rd1;
    end

    // --------------------
    // banks

    dp_ram bunit1 (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (bank1_wr),
        .rd     (bank1_rd),
        .rdata  (bank1_q)
    );

    dp_ram bunit2 (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (bank2_wr),
        .rd     (bank2_rd),
        .rdata  (bank2_q)
    );

    // --------------------
    // output crossing

    // read data is one cycle behind its address, so is the select
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q <= 1'b1;
        end else begin
            ctrl_q <= ctrl;
        end
    end

    assign dout1 = ctrl_q ? bank1_q : bank2_q;
    assign dout2 = ctrl_q ? bank2_q : bank1_q;

    // --------------------
    // checks

    // sweep owns both write ports
    a_no_fill_during_clear: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(wr1.en && clear)
    );

    // a swap only lands on the first read of a burst
    // the one before it must be a full frame back, so the burst never crosses banks
    a_ctrl_held_for_burst: assert property (
        @(posedge clk) disable iff (!arst_n)
        (rd2.en && $changed(ctrl)) |-> ($past(ctrl, FRAME_LEN) == $past(ctrl))
    );

endmodule

/* frame_writer.sv */
`include "pp_reorder_consts.svh"

module frame_writer import pp_reorder_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  logic [`DATA_WIDTH-1:0] in_data,
    input  order_e                 order_in,
    output wr_port_t               wr,
    output logic                   clear,
    output logic                   ctrl,
    output logic                   frame_ready,
    output logic                   init_busy,
    output order_e                 frame_order
);

    localparam int AW        = `ADDR_WIDTH;
    localparam int FRAME_LEN = `FRAME_LEN;

    wr_state_e              state;
    logic [AW-1:0]          cnt;
    logic                   last;
    logic                   wr_en_q;
    logic [AW-1:0]          wr_addr_q;
    logic [`DATA_WIDTH-1:0] wr_data_q;

    // shared by the sweep and the sample count
    assign last = (cnt == AW'(FRAME_LEN - 1));

    // --------------------
    // FSM

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ST_CLEAR;
            cnt         <= '0;
            wr_en_q     <= 1'b0;
            frame_ready <= 1'b0;
            frame_order <= ORDER_LINEAR;
            ctrl        <= 1'b1;
        end else begin
            wr_en_q     <= 1'b0;
            frame_ready <= 1'b0;

            // swap one cycle after the last sample, once its write is done
            if (frame_ready) begin
                ctrl <= ~ctrl;
            end

            case (state)
                ST_CLEAR: begin
                    cnt <= cnt + 1'b1;
                    if (last) begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (in_valid) begin
                        wr_en_q <= 1'b1;
                        cnt     <= cnt + 1'b1;
                        if (last) begin
                            frame_ready <= 1'b1;
                            frame_order <= order_in;
                        end
                    end
                end
            endcase
        end
    end

    // sample stage in front of the bank
    always_ff @(posedge clk) begin
        if (state == ST_FILL && in_valid) begin
            wr_addr_q <= cnt;
            wr_data_q <= in_data;
        end
    end

    assign clear     = (state == ST_CLEAR);
    assign init_busy = clear;

    // sweep address comes straight from the counter
    assign wr.en   = wr_en_q;
    assign wr.addr = clear ? cnt : wr_addr_q;
    assign wr.data = clear ? '0 : wr_data_q;

endmodule

/* frame_reader.sv */
`include "pp_reorder_consts.svh"

module frame_reader import pp_reorder_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   frame_ready,
    input  order_e                 frame_order,
    input  logic [`DATA_WIDTH-1:0] rdata,
    output rd_port_t               rd,
    output wr_port_t               wr,
    output logic                   out_valid,
    output logic [`DATA_WIDTH-1:0] out_data
);

    localparam int AW        = `ADDR_WIDTH;
    localparam int FRAME_LEN = `FRAME_LEN;

    rd_state_e     state;
    logic [AW-1:0] cnt;
    logic          rd_en;
    logic [AW-1:0] rd_addr;

    // --------------------
    // address walk

    // ST_READ covers the first 15 reads
    // the 16th goes out from ST_IDLE, which can already take the next frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            cnt       <= '0;
            rd_en     <= 1'b0;
            rd_addr   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;

            case (state)
                ST_IDLE: begin
                    rd_en <= frame_ready;
                    if (frame_ready) begin
                        state   <= ST_READ;
                        cnt     <= '0;
                        rd_addr <= (frame_order == ORDER_REVERSED) ? '1 : '0;
                    end
                end
                ST_READ: begin
                    cnt <= cnt + 1'b1;
                    if (frame_order == ORDER_REVERSED) begin
                        rd_addr <= rd_addr - 1'b1;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                    if (cnt == AW'(FRAME_LEN - 2)) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    assign rd.en   = rd_en;
    assign rd.addr = rd_addr;

    // zero each word as it is read, the bank is read first
    assign wr.en   = rd_en;
    assign wr.addr = rd_addr;
    assign wr.data = '0;

    assign out_data = rdata;

    // --------------------
    // checks

    // a frame takes 16 samples, so the walk is always done in time
    a_no_ready_while_reading: assert property (
        @(posedge clk) disable iff (!arst_n)
        frame_ready |-> (state == ST_IDLE)
    );

endmodule

/* pp_reorder_top.sv */
`include "pp_reorder_consts.svh"

module pp_reorder_top import pp_reorder_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  logic [`DATA_WIDTH-1:0] in_data,
    input  order_e                 order_in,
    input  logic                   peek_en,
    input  logic [`ADDR_WIDTH-1:0] peek_addr,
    output logic                   init_busy,
    output logic                   out_valid,
    output logic [`DATA_WIDTH-1:0] out_data,
    output logic [`DATA_WIDTH-1:0] peek_data
);

    // writer side
    wr_port_t               fill_wr;
    logic                   clear;
    logic                   ctrl;
    logic                   frame_ready;
    order_e                 frame_order;

    // reader side
    rd_port_t               drain_rd;
    wr_port_t               drain_wr;
    logic [`DATA_WIDTH-1:0] drain_data;

    // peek goes through the filling bank's read port
    rd_port_t               peek_rd;

    assign peek_rd.en   = peek_en;
    assign peek_rd.addr = peek_addr;

    frame_writer i_frame_writer (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .order_in    (order_in),
        .wr          (fill_wr),
        .clear       (clear),
        .ctrl        (ctrl),
        .frame_ready (frame_ready),
        .init_busy   (init_busy),
        .frame_order (frame_order)
    );

    frame_reader i_frame_reader (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_ready (frame_ready),
        .frame_order (frame_order),
        .rdata       (drain_data),
        .rd          (drain_rd),
        .wr          (drain_wr),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    pq_buffer i_pq_buffer (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (ctrl),
        .clear  (clear),
        .wr1    (fill_wr),
        .wr2    (drain_wr),
        .rd1    (peek_rd),
        .rd2    (drain_rd),
        .dout1  (peek_data),
        .dout2  (drain_data)
    );

endmodule

/* tb_pp_reorder.sv */
`include "pp_reorder_consts.svh"

module tb_pp_reorder import pp_reorder_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DW = `DATA_WIDTH;
    localparam int AW = `ADDR_WIDTH;
    localparam int FL = `FRAME_LEN;

    // frames per test
    localparam int N_INIT = 1;
    localparam int N_LIN  = 6;
    localparam int N_REV  = 6;
    localparam int N_PP   = 8;
    localparam int N_PEEK = 6;
    localparam int WATCHDOG_CYCLES = (N_INIT + N_LIN + N_REV + N_PP + N_PEEK) * 40 + 1000;

    logic          clk;
    logic          arst_n;
    logic          in_valid;
    logic [DW-1:0] in_data;
    order_e        order_in;
    logic          peek_en;
    logic [AW-1:0] peek_addr;
    logic          init_busy;
    logic          out_valid;
    logic [DW-1:0] out_data;
    logic [DW-1:0] peek_data;

    // --------------------
    // reference model

    logic [DW-1:0] bank [2][FL];
    logic [DW-1:0] frame_buf [FL];
    logic [AW-1:0] fill_cnt;
    logic          ctrl_m;
    logic          wr_pend;
    logic [AW-1:0] wr_addr_m;
    logic [DW-1:0] wr_data_m;
    logic          swap_pend;
    logic          peek_pend;
    logic [AW-1:0] peek_addr_m;
    logic [DW-1:0] peek_exp;
    logic [DW-1:0] exp_q [$];
    logic [DW-1:0] exp_word;

    string cur_test;
    int    err_count;
    int    check_count;
    int    out_count;
    int    busy_cycles;
    int    n_tests;

    pp_reorder_top i_pp_reorder_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .order_in  (order_in),
        .peek_en   (peek_en),
        .peek_addr (peek_addr),
        .init_busy (init_busy),
        .out_valid (out_valid),
        .out_data  (out_data),
        .peek_data (peek_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // sweep length seen at the top level
    always @(negedge clk) begin
        if (arst_n && init_busy) begin
            busy_cycles++;
        end
    end

    // output words against the expected queue
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            out_count++;
            check_count++;
            assert (exp_q.size() > 0) else begin
                err_count++;
                $display("%s: output word arrived with no frame pending", cur_test);
            end
            if (exp_q.size() > 0) begin
                exp_word = exp_q.pop_front();
                check_count++;
                assert (out_data === exp_word) else begin
                    err_count++;
                    $display("MISMATCH %s out_data expected %02h actual %02h",
                             cur_test, exp_word, out_data);
                end
            end
        end
    end

    // coin flip between the two read orders
    function automatic order_e random_order();
        return ($urandom_range(1) == 1) ? ORDER_REVERSED : ORDER_LINEAR;
    endfunction

    // one clock of stimulus and the model update for the next edge
    task automatic cycle(input logic v, input logic [DW-1:0] d, input order_e o,
                         input logic pe, input logic [AW-1:0] pa);
        int i;
        @(posedge clk);
        #2;
        if (peek_pend) begin
            check_count++;
            assert (peek_data === peek_exp) else begin
                err_count++;
                $display("MISMATCH %s peek[%0d] expected %02h actual %02h",
                         cur_test, peek_addr_m, peek_exp, peek_data);
            end
        end
        in_valid  = v;
        in_data   = d;
        order_in  = o;
        peek_en   = pe;
        peek_addr = pa;

        // read first, so the peek sees the bank before this edge writes
        peek_pend   = pe;
        peek_addr_m = pa;
        peek_exp    = bank[ctrl_m][pa];

        // sample accepted last edge lands now
        if (wr_pend) begin
            bank[ctrl_m][wr_addr_m] = wr_data_m;
        end
        // new filling bank was zeroed by its read pass
        if (swap_pend) begin
            ctrl_m = ~ctrl_m;
            for (i = 0; i < FL; i++) begin
                bank[ctrl_m][AW'(i)] = '0;
            end
            swap_pend = 1'b0;
        end

        wr_pend = 1'b0;
        if (v) begin
            wr_pend   = 1'b1;
            wr_addr_m = fill_cnt;
            wr_data_m = d;
            frame_buf[fill_cnt] = d;
            if (fill_cnt == '1) begin
                for (i = 0; i < FL; i++) begin
                    if (o == ORDER_REVERSED) begin
                        exp_q.push_back(frame_buf[AW'(FL - 1 - i)]);
                    end else begin
                        exp_q.push_back(frame_buf[AW'(i)]);
                    end
                end
                swap_pend = 1'b1;
            end
            fill_cnt = fill_cnt + 1'b1;
        end
    endtask

    // junk samples while the sweep runs must all be dropped
    task automatic wait_init();
        do begin
            @(posedge clk);
            #2;
            in_valid = init_busy;
            in_data  = DW'($urandom);
        end while (init_busy);
    endtask

    // order_mode 0 linear, 1 reversed, 2 random per frame
    task automatic run_frames(input int nframes, input int order_mode,
                              input int gap_pct, input int peek_pct);
        int            outs_before;
        order_e        ord;
        order_e        smp_ord;
        logic          pe;
        logic [AW-1:0] pa;
        outs_before = out_count;
        for (int f = 0; f < nframes; f++) begin
            if (order_mode == 2) begin
                ord = random_order();
            end else begin
                ord = (order_mode == 1) ? ORDER_REVERSED : ORDER_LINEAR;
            end
            for (int s = 0; s < FL; s++) begin
                while ($urandom_range(99) < gap_pct) begin
                    pe = ($urandom_range(99) < peek_pct);
                    pa = AW'($urandom);
                    cycle(1'b0, '0, random_order(), pe, pa);
                end
                pe = ($urandom_range(99) < peek_pct);
                pa = AW'($urandom);
                // only the last sample's order decides the frame
                smp_ord = (s == FL - 1) ? ord : random_order();
                cycle(1'b1, DW'($urandom), smp_ord, pe, pa);
            end
        end
        // drain until every expected word came out
        while (exp_q.size() != 0) begin
            cycle(1'b0, '0, random_order(), 1'b0, '0);
        end
        check_count++;
        assert (out_count - outs_before == nframes * FL) else begin
            err_count++;
            $display("MISMATCH %s word count expected %0d actual %0d",
                     cur_test, nframes * FL, out_count - outs_before);
        end
    endtask

    task automatic report_test(input int errs_before, input int nframes);
        n_tests++;
        $display("test %-10s %0d frames  %s", cur_test, nframes,
                 (err_count == errs_before) ? "ok" : "FAILED");
    endtask

    // --------------------
    // test sequence

    initial begin
        int e0;
        void'($urandom(32'h3b86));
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        order_in  = ORDER_LINEAR;
        peek_en   = 1'b0;
        peek_addr = '0;
        for (int i = 0; i < FL; i++) begin
            bank[0][AW'(i)] = '0;
            bank[1][AW'(i)] = '0;
        end
        fill_cnt  = '0;
        ctrl_m    = 1'b1;
        wr_pend   = 1'b0;
        swap_pend = 1'b0;
        peek_pend = 1'b0;

        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;

        cur_test = "reset_init";
        e0 = err_count;
        wait_init();
        check_count++;
        assert (busy_cycles == FL) else begin
            err_count++;
            $display("MISMATCH %s init_busy cycles expected %0d actual %0d",
                     cur_test, FL, busy_cycles);
        end
        run_frames(N_INIT, 0, 20, 60);
        report_test(e0, N_INIT);

        cur_test = "linear";
        e0 = err_count;
        run_frames(N_LIN, 0, 30, 10);
        report_test(e0, N_LIN);

        cur_test = "reversed";
        e0 = err_count;
        run_frames(N_REV, 1, 30, 10);
        report_test(e0, N_REV);

        // no gaps so fill and drain overlap on every frame
        cur_test = "ping_pong";
        e0 = err_count;
        run_frames(N_PP, 2, 0, 20);
        report_test(e0, N_PP);

        cur_test = "peek";
        e0 = err_count;
        run_frames(N_PEEK, 2, 25, 80);
        report_test(e0, N_PEEK);

        $display("tests %0d, checks %0d, errors %0d", n_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

/* pp_reorder.f */
+incdir+.
pp_reorder_pkg.sv
dp_ram.sv
pq_buffer.sv
frame_writer.sv
frame_reader.sv
pp_reorder_top.sv
tb_pp_reorder.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := tb_pp_reorder
FLIST    := pp_reorder.f
OBJ      := obj_dir
LOG      := sim.log
FAIL_MSG := Errors found

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	@./$(OBJ)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)
